/* verilog/snake_vga_params.svh */
//------------------------------
// VGA timing, map geometry, register map
// and tile code values for the snake display
//------------------------------
`ifndef SNAKE_VGA_PARAMS_SVH
`define SNAKE_VGA_PARAMS_SVH

// horizontal, in clocks (two per pixel)
`define SV_HACTIVE 1280
`define SV_HFRONT 32
`define SV_HSYNC 192
`define SV_HBACK 96
`define SV_HTOTAL 1600

// vertical, in lines
`define SV_VACTIVE 480
`define SV_VFRONT 10
`define SV_VSYNC 2
`define SV_VBACK 33
`define SV_VTOTAL 525

// tile map, 16x16 pixel tiles, four entries per bus word
`define SV_MAP_COLS 40
`define SV_MAP_ROWS 30
`define SV_WORDS_PER_ROW 10
`define SV_MAP_WORDS 300
`define SV_ADDR_BITS 9

// palette registers
`define SV_REG_BG 9'h130
`define SV_REG_APPLE 9'h131
`define SV_REG_HEAD 9'h132
`define SV_REG_BODY 9'h133
`define SV_REG_WALL 9'h134

// wall border, in 32x32 blocks
`define SV_WALL_TOP_BLOCK 1
`define SV_WALL_BOTTOM_BLOCK 14
`define SV_WALL_RIGHT_BLOCK 19

// tile codes
`define SV_TILE_EMPTY 8'd0
`define SV_TILE_APPLE 8'd1
`define SV_TILE_HEAD 8'd2
`define SV_TILE_BODY 8'd3

`endif

/* verilog/snake_vga_pkg.sv */
//------------------------------
// tile kind enum and the packed structs
// passed between the display blocks
//------------------------------
`include "snake_vga_params.svh"

package snake_vga_pkg;

  // codes outside this set draw as empty
  typedef enum logic [7:0] {
    TILE_EMPTY = `SV_TILE_EMPTY,
    TILE_APPLE = `SV_TILE_APPLE,
    TILE_HEAD  = `SV_TILE_HEAD,
    TILE_BODY  = `SV_TILE_BODY
  } tile_kind_e;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  typedef struct packed {
    logic [10:0] hcount;
    logic [9:0]  vcount;
  } pix_pos_t;

  typedef struct packed {
    logic hs;
    logic vs;
    logic blank_n;
    logic pix_clk;
  } vga_sync_t;

  typedef struct packed {
    rgb_t bg;
    rgb_t apple;
    rgb_t head;
    rgb_t body;
    rgb_t wall;
  } palette_t;

  // sel is chipselect and write combined
  typedef struct packed {
    logic                     sel;
    logic [`SV_ADDR_BITS-1:0] address;
    logic [31:0]              data;
  } bus_write_t;

endpackage

/* verilog/vga_timing.sv */
//------------------------------
// 640x480 VGA counters with sync, blank
// and pixel clock decode
//------------------------------
`timescale 1ns/1ps
`include "snake_vga_params.svh"

module vga_timing
  import snake_vga_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  output pix_pos_t  pos,
  output vga_sync_t sync
);

  localparam logic [10:0] H_LAST = 11'(`SV_HTOTAL - 1);
  localparam logic [9:0]  V_LAST = 10'(`SV_VTOTAL - 1);

  // sync pulse windows, both inclusive
  localparam logic [10:0] HS_START = 11'(`SV_HACTIVE + `SV_HFRONT);
  localparam logic [10:0] HS_END   = 11'(`SV_HACTIVE + `SV_HFRONT + `SV_HSYNC - 1);
  localparam logic [9:0]  VS_START = 10'(`SV_VACTIVE + `SV_VFRONT);
  localparam logic [9:0]  VS_END   = 10'(`SV_VACTIVE + `SV_VFRONT + `SV_VSYNC - 1);

  logic [10:0] hcount;
  logic [9:0]  vcount;
  logic        end_of_line;
  logic        end_of_frame;

  assign end_of_line  = (hcount == H_LAST);
  assign end_of_frame = (vcount == V_LAST);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      hcount <= '0;
    end else if (end_of_line) begin
      hcount <= '0;
    end else begin
      hcount <= hcount + 11'd1;
    end
  end

  // vertical steps once per line
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      vcount <= '0;
    end else if (end_of_line) begin
      if (end_of_frame) begin
        vcount <= '0;
      end else begin
        vcount <= vcount + 10'd1;
      end
    end
  end

  assign pos.hcount = hcount;
  assign pos.vcount = vcount;

  // sync is active low
  assign sync.hs      = !((hcount >= HS_START) && (hcount <= HS_END));
  assign sync.vs      = !((vcount >= VS_START) && (vcount <= VS_END));
  assign sync.blank_n = (hcount < 11'(`SV_HACTIVE)) && (vcount < 10'(`SV_VACTIVE));
  // one pixel every other clock
  assign sync.pix_clk = hcount[0];

endmodule

/* verilog/tile_map_regs.sv */
//------------------------------
// tile map memory and palette registers,
// bus writes and tile lookup
//------------------------------
`timescale 1ns/1ps
`include "snake_vga_params.svh"

module tile_map_regs
  import snake_vga_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  bus_write_t bus,
  input  logic [5:0] tile_col,
  input  logic [4:0] tile_row,
  output tile_kind_e tile_code,
  output palette_t   palette
);

  localparam int unsigned WORD_BITS = $clog2(`SV_MAP_WORDS);

  logic [31:0]          map_mem [`SV_MAP_WORDS];
  logic [WORD_BITS-1:0] rd_idx;
  logic [31:0]          rd_word;
  logic [7:0]           rd_byte;

  //------------------------------
  // write side
  //------------------------------
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `SV_MAP_WORDS; i++) begin
        map_mem[i] <= '0;
      end
    end else if (bus.sel && (bus.address < `SV_ADDR_BITS'(`SV_MAP_WORDS))) begin
      // leftmost column of the word sits in bits 31:24
      map_mem[bus.address] <= bus.data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      palette <= '0;
    end else if (bus.sel) begin
      case (bus.address)
        `SV_REG_BG:    palette.bg    <= rgb_t'(bus.data[23:0]);
        `SV_REG_APPLE: palette.apple <= rgb_t'(bus.data[23:0]);
        `SV_REG_HEAD:  palette.head  <= rgb_t'(bus.data[23:0]);
        `SV_REG_BODY:  palette.body  <= rgb_t'(bus.data[23:0]);
        `SV_REG_WALL:  palette.wall  <= rgb_t'(bus.data[23:0]);
        default: ;
      endcase
    end
  end

  //------------------------------
  // read side
  //------------------------------
  // word = row * 10 + col / 4
  assign rd_idx = WORD_BITS'(tile_row) * WORD_BITS'(`SV_WORDS_PER_ROW)
                + WORD_BITS'(tile_col[5:2]);

  // coordinates past the map only occur while blanked
  always_comb begin
    if ((tile_col < 6'(`SV_MAP_COLS)) && (tile_row < 5'(`SV_MAP_ROWS))) begin
      rd_word = map_mem[rd_idx];
    end else begin
      rd_word = '0;
    end
  end

  always_comb begin
    case (tile_col[1:0])
      2'd0:    rd_byte = rd_word[31:24];
      2'd1:    rd_byte = rd_word[23:16];
      2'd2:    rd_byte = rd_word[15:8];
      default: rd_byte = rd_word[7:0];
    endcase
  end

  assign tile_code = tile_kind_e'(rd_byte);

endmodule

/* verilog/tile_renderer.sv */
//------------------------------
// per-pixel tile and wall classification,
// colour pick and output register
//------------------------------
`timescale 1ns/1ps
`include "snake_vga_params.svh"

module tile_renderer
  import snake_vga_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  pix_pos_t   pos,
  input  vga_sync_t  sync,
  output logic [5:0] tile_col,
  output logic [4:0] tile_row,
  input  tile_kind_e tile_code,
  input  palette_t   palette,
  output rgb_t       rgb,
  output vga_sync_t  vga_sync
);

  localparam logic [4:0] WALL_TOP    = 5'(`SV_WALL_TOP_BLOCK);
  localparam logic [4:0] WALL_BOTTOM = 5'(`SV_WALL_BOTTOM_BLOCK);
  localparam logic [4:0] WALL_RIGHT  = 5'(`SV_WALL_RIGHT_BLOCK);

  // idle outputs, syncs inactive and screen blanked
  localparam vga_sync_t SYNC_IDLE = '{hs: 1'b1, vs: 1'b1, blank_n: 1'b0, pix_clk: 1'b0};

  logic [4:0] block_col;
  logic [4:0] block_row;
  logic       is_wall;
  rgb_t       rgb_next;

  // 16x16 tiles, hcount counts two clocks per pixel
  assign tile_col = pos.hcount[10:5];
  // vcount bit 9 only set outside the active area
  assign tile_row = pos.vcount[8:4];

  // 32x32 wall blocks
  assign block_col = pos.hcount[10:6];
  assign block_row = pos.vcount[9:5];

  // side columns start below the top row
  assign is_wall = (((block_col == 5'd0) || (block_col == WALL_RIGHT))
                    && (block_row > WALL_TOP))
                 || (block_row == WALL_TOP)
                 || (block_row == WALL_BOTTOM);

  //------------------------------
  // colour priority
  //------------------------------
  always_comb begin
    if (!sync.blank_n) begin
      rgb_next = '0;
    end else begin
      case (tile_code)
        TILE_APPLE: rgb_next = palette.apple;
        TILE_HEAD:  rgb_next = palette.head;
        TILE_BODY:  rgb_next = palette.body;
        // empty and unknown codes
        default: begin
          if (is_wall) begin
            rgb_next = palette.wall;
          end else begin
            rgb_next = palette.bg;
          end
        end
      endcase
    end
  end

  // colour and sync stay aligned
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      rgb      <= '0;
      vga_sync <= SYNC_IDLE;
    end else begin
      rgb      <= rgb_next;
      vga_sync <= sync;
    end
  end

endmodule

/* verilog/snake_vga.sv */
//------------------------------
// snake tile display top level
//------------------------------
`timescale 1ns/1ps
`include "snake_vga_params.svh"

module snake_vga
  import snake_vga_pkg::*;
(
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     chipselect,
  input  logic                     write,
  input  logic [`SV_ADDR_BITS-1:0] address,
  input  logic [31:0]              writedata,
  output logic [7:0]               vga_r,
  output logic [7:0]               vga_g,
  output logic [7:0]               vga_b,
  output logic                     vga_clk,
  output logic                     vga_hs,
  output logic                     vga_vs,
  output logic                     vga_blank_n
);

  pix_pos_t   pos;
  vga_sync_t  sync;
  vga_sync_t  sync_out;
  bus_write_t bus;
  logic [5:0] tile_col;
  logic [4:0] tile_row;
  tile_kind_e tile_code;
  palette_t   palette;
  rgb_t       rgb;

  assign bus = '{sel: chipselect & write, address: address, data: writedata};

  vga_timing timing (
    .clk   (clk),
    .reset (reset),
    .pos   (pos),
    .sync  (sync)
  );

  tile_map_regs regs (
    .clk       (clk),
    .reset     (reset),
    .bus       (bus),
    .tile_col  (tile_col),
    .tile_row  (tile_row),
    .tile_code (tile_code),
    .palette   (palette)
  );

  tile_renderer renderer (
    .clk       (clk),
    .reset     (reset),
    .pos       (pos),
    .sync      (sync),
    .tile_col  (tile_col),
    .tile_row  (tile_row),
    .tile_code (tile_code),
    .palette   (palette),
    .rgb       (rgb),
    .vga_sync  (sync_out)
  );

  assign vga_r       = rgb.r;
  assign vga_g       = rgb.g;
  assign vga_b       = rgb.b;
  assign vga_clk     = sync_out.pix_clk;
  assign vga_hs      = sync_out.hs;
  assign vga_vs      = sync_out.vs;
  assign vga_blank_n = sync_out.blank_n;

endmodule

/* verif/snake_vga_tb.sv */
//------------------------------
// testbench for the snake tile display
// file-driven bus writes and pixel checks,
// position model, sync sweeps, timeout
//------------------------------
`timescale 1ns/1ps
`include "snake_vga_params.svh"

module snake_vga_tb;

  localparam int H_TOTAL      = `SV_HTOTAL;
  localparam int H_ACTIVE     = `SV_HACTIVE;
  localparam int V_ACTIVE     = `SV_VACTIVE;
  localparam int FRAME_CYCLES = `SV_HTOTAL * `SV_VTOTAL;
  localparam int HS_FIRST     = `SV_HACTIVE + `SV_HFRONT;
  localparam int HS_LAST      = `SV_HACTIVE + `SV_HFRONT + `SV_HSYNC - 1;
  localparam int VS_FIRST     = `SV_VACTIVE + `SV_VFRONT;
  localparam int VS_LAST      = `SV_VACTIVE + `SV_VFRONT + `SV_VSYNC - 1;
  localparam string INPUT_FILE = "verif/snake_vga_input.txt";

  logic                     clk = 1'b0;
  logic                     reset;
  logic                     chipselect;
  logic                     write;
  logic [`SV_ADDR_BITS-1:0] address;
  logic [31:0]              writedata;
  logic [7:0]               vga_r;
  logic [7:0]               vga_g;
  logic [7:0]               vga_b;
  logic                     vga_clk;
  logic                     vga_hs;
  logic                     vga_vs;
  logic                     vga_blank_n;

  // parsed commands, one entry per line
  byte         cmd_q[$];
  int          arg_a[$];
  int          arg_b[$];
  logic [31:0] arg_c[$];

  // linear position shown on the outputs
  int pos_lin;
  int cycles = 0;
  int cycle_limit = 0;

  snake_vga UUT (
    .clk         (clk),
    .reset       (reset),
    .chipselect  (chipselect),
    .write       (write),
    .address     (address),
    .writedata   (writedata),
    .vga_r       (vga_r),
    .vga_g       (vga_g),
    .vga_b       (vga_b),
    .vga_clk     (vga_clk),
    .vga_hs      (vga_hs),
    .vga_vs      (vga_vs),
    .vga_blank_n (vga_blank_n)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    if (!reset) begin
      cycles = cycles + 1;
      if (cycles >= cycle_limit) begin
        $display("checks did not finish within %0d cycles", cycle_limit);
        $display("Simulation failed");
        $fatal(1);
      end
    end
  end

  function automatic int cur_h();
    return pos_lin % H_TOTAL;
  endfunction

  function automatic int cur_v();
    return pos_lin / H_TOTAL;
  endfunction

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error %s expected %0h got %0h", name, expected, actual);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  task automatic reject_line(input string line);
    $display("unreadable line in the input file: %s", line);
    $display("Simulation failed");
    $fatal(1);
  endtask

  // one clock, then settle past the edge
  task automatic advance_clock();
    @(posedge clk);
    #1;
    pos_lin = (pos_lin + 1) % FRAME_CYCLES;
  endtask

  task automatic wait_for_pos(input int h, input int v);
    advance_clock();
    while ((cur_h() != h) || (cur_v() != v)) begin
      advance_clock();
    end
  endtask

  task automatic bus_write(input int addr, input logic [31:0] data);
    address    = `SV_ADDR_BITS'(addr);
    writedata  = data;
    chipselect = 1'b1;
    write      = 1'b1;
    advance_clock();
    chipselect = 1'b0;
    write      = 1'b0;
  endtask

  task automatic verify_reset_state();
    compare("vga_r", 32'h0, 32'(vga_r));
    compare("vga_g", 32'h0, 32'(vga_g));
    compare("vga_b", 32'h0, 32'(vga_b));
    compare("vga_hs", 32'h1, 32'(vga_hs));
    compare("vga_vs", 32'h1, 32'(vga_vs));
    compare("vga_blank_n", 32'h0, 32'(vga_blank_n));
    compare("vga_clk", 32'h0, 32'(vga_clk));
  endtask

  // pixel x sits at hcount 2x
  task automatic verify_pixel(input int x, input int y, input logic [31:0] rgb);
    wait_for_pos(2 * x, y);
    compare("vga_r", 32'(rgb[23:16]), 32'(vga_r));
    compare("vga_g", 32'(rgb[15:8]), 32'(vga_g));
    compare("vga_b", 32'(rgb[7:0]), 32'(vga_b));
  endtask

  task automatic sweep_line(input int y);
    logic hs_exp;
    logic vs_exp;
    logic blank_exp;
    wait_for_pos(0, y);
    for (int h = 0; h < H_TOTAL; h++) begin
      if (h > 0) begin
        advance_clock();
      end
      hs_exp    = !((h >= HS_FIRST) && (h <= HS_LAST));
      vs_exp    = !((y >= VS_FIRST) && (y <= VS_LAST));
      blank_exp = (h < H_ACTIVE) && (y < V_ACTIVE);
      compare("vga_hs", 32'(hs_exp), 32'(vga_hs));
      compare("vga_vs", 32'(vs_exp), 32'(vga_vs));
      compare("vga_blank_n", 32'(blank_exp), 32'(vga_blank_n));
      compare("vga_clk", 32'(h % 2), 32'(vga_clk));
      // black while blanked
      if (!blank_exp) begin
        compare("vga_r", 32'h0, 32'(vga_r));
        compare("vga_g", 32'h0, 32'(vga_g));
        compare("vga_b", 32'h0, 32'(vga_b));
      end
    end
  endtask

  //------------------------------
  // command file
  //------------------------------
  task automatic load_commands();
    int          fd;
    int          n;
    int          p;
    int          last_p;
    int          frames;
    int          a;
    int          b;
    logic [31:0] c;
    byte         op;
    string       line;
    fd = $fopen(INPUT_FILE, "r");
    if (fd == 0) begin
      $display("could not open the input file %s", INPUT_FILE);
      $display("Simulation failed");
      $fatal(1);
    end
    last_p = -1;
    frames = 1;
    while ($fgets(line, fd) != 0) begin
      op = line.getc(0);
      a  = 0;
      b  = 0;
      c  = '0;
      p  = 0;
      case (op)
        "W": begin
          n = $sscanf(line, "W %h %h", a, c);
          if (n != 2) begin
            reject_line(line);
          end
        end
        "C": begin
          n = $sscanf(line, "C %d %d %h", a, b, c);
          if (n != 3) begin
            reject_line(line);
          end
          p = b * H_TOTAL + 2 * a;
        end
        "S": begin
          n = $sscanf(line, "S %d", b);
          if (n != 1) begin
            reject_line(line);
          end
          p = b * H_TOTAL;
        end
        "#", " ", "\t", "\n", "\r": op = 0;
        default: reject_line(line);
      endcase
      // a check at or before the last one waits for the next frame
      if ((op == "C") || (op == "S")) begin
        if (p <= last_p) begin
          frames++;
        end
        last_p = (op == "S") ? p + H_TOTAL - 1 : p;
      end
      if (op != 0) begin
        cmd_q.push_back(op);
        arg_a.push_back(a);
        arg_b.push_back(b);
        arg_c.push_back(c);
      end
    end
    $fclose(fd);
    cycle_limit = frames * FRAME_CYCLES + 2000;
  endtask

  task automatic run_commands();
    for (int i = 0; i < cmd_q.size(); i++) begin
      case (cmd_q[i])
        "W":     bus_write(arg_a[i], arg_c[i]);
        "C":     verify_pixel(arg_a[i], arg_b[i], arg_c[i]);
        default: sweep_line(arg_b[i]);
      endcase
    end
  endtask

  initial begin
    reset      = 1'b1;
    chipselect = 1'b0;
    write      = 1'b0;
    address    = '0;
    writedata  = '0;
    pos_lin    = -1;
    load_commands();
    repeat (10) @(posedge clk);
    #1;
    verify_reset_state();
    reset = 1'b0;
    run_commands();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

/* verif/snake_vga_input.txt */
# W <addr hex> <data hex>        bus write
# C <x dec> <y dec> <rgb hex>    expected colour of pixel x,y
# S <y dec>                      sync, blank and black check over line y
# palette, top byte of bg is ignored
W 130 aa102030
W 131 00ff0000
W 132 0000ff00
W 133 000000ff
W 134 00808080
# row 10 cols 8..11, then the neighbouring word cols 12..15
W 066 01020307
W 067 03000201
# apple on the top wall, unknown code on the left wall
W 019 01000000
W 0c8 07000000
S 1
C 10 10 102030
C 10 40 808080
C 324 40 ff0000
C 340 40 808080
C 620 40 808080
C 136 165 ff0000
C 152 165 00ff00
C 168 165 0000ff
C 184 165 102030
C 200 165 0000ff
C 216 165 102030
C 232 165 00ff00
C 248 165 ff0000
C 10 200 808080
C 620 200 808080
C 400 250 102030
C 5 325 808080
C 300 460 808080
S 479
S 480
S 490
S 491
S 492
# new body colour, seen from the next frame
W 133 00c0ffee
C 136 165 ff0000
C 152 165 00ff00
C 168 165 c0ffee
C 184 165 102030
C 200 165 c0ffee
C 232 165 00ff00
C 324 40 ff0000
C 10 200 808080

/* snake_vga.f */
+incdir+verilog
verilog/snake_vga_pkg.sv
verilog/vga_timing.sv
verilog/tile_map_regs.sv
verilog/tile_renderer.sv
verilog/snake_vga.sv
verif/snake_vga_tb.sv

/* Makefile */
# Verilator build and run for the snake tile display

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module snake_vga_tb \
		-f snake_vga.f -o snake_vga_sim
	./obj_dir/snake_vga_sim | awk '{ print } \
		/^Simulation completed successfully$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
